// ==== ctlRegTop.f ====
hw/ctlPkg.sv
hw/busDecode.sv
hw/ctlRegBank.sv
hw/flagDebounce.sv
hw/readPort.sv
hw/ctlRegTop.sv
test/ctlRegTop_properties.sv
test/ctlRegTopTb.sv

// ==== hw/busDecode.sv ====
module busDecode #(
  parameter logic [ctlPkg::AddrWidth-1:0] BaseAddr = 14'h3FE0
) (
  input  logic                         access,
  input  logic                         write,
  input  logic [ctlPkg::AddrWidth-1:0] addr,
  output ctlPkg::regSel                sel,
  output logic                         wrEn,
  output logic                         rdEn
);

  logic [ctlPkg::AddrWidth-1:0] offset;

  // Offset from the block base, wrapping like the address bus.
  assign offset = addr - BaseAddr;

  always_comb begin
    case (offset)
      14'd0: begin
        sel = ctlPkg::RegSysCtl;
      end
      14'd1: begin
        sel = ctlPkg::RegMemWait;
      end
      14'd2: begin
        sel = ctlPkg::RegTimer;
      end
      14'd3: begin
        sel = ctlPkg::RegPattern;
      end
      14'd4: begin
        sel = ctlPkg::RegIntMask;
      end
      14'd5: begin
        sel = ctlPkg::RegFlags;
      end
      default: begin
        sel = ctlPkg::RegNone;
      end
    endcase
  end

  // Direction is qualified by the access strobe.
  assign wrEn = access & write;
  assign rdEn = access & ~write;

endmodule

// ==== hw/ctlPkg.sv ====
package ctlPkg;

  // Bus geometry of the DSP core.
  localparam int DataWidth = 16;
  localparam int AddrWidth = 14;

  // Register map in address order, starting at the base address.
  typedef enum logic [2:0] {
    RegSysCtl  = 3'd0,
    RegMemWait = 3'd1,
    RegTimer   = 3'd2,
    RegPattern = 3'd3,
    RegIntMask = 3'd4,
    RegFlags   = 3'd5,
    RegNone    = 3'd6
  } regSel;

  // Implemented width of each writable register.
  localparam int SysCtlWidth  = 16;
  localparam int MemWaitWidth = 16;
  localparam int TimerWidth   = 15;
  localparam int PatternWidth = 8;
  localparam int IntMaskWidth = 12;

  // Values loaded while CLR is high.
  localparam logic [SysCtlWidth-1:0]  SysCtlReset  = 16'h0800;
  // Max wait states on every memory space.
  localparam logic [MemWaitWidth-1:0] MemWaitReset = 16'hC3FF;
  localparam logic [TimerWidth-1:0]   TimerReset   = 15'h7FFF;
  // Alternating bits, easy to spot on a scope.
  localparam logic [PatternWidth-1:0] PatternReset = 8'h55;
  localparam logic [IntMaskWidth-1:0] IntMaskReset = 12'h000;

endpackage

// ==== hw/ctlRegBank.sv ====
module ctlRegBank (
  input  logic                            CLK,
  input  logic                            CLR,
  input  logic                            hold,
  input  ctlPkg::regSel                   sel,
  input  logic                            wrEn,
  input  logic [ctlPkg::DataWidth-1:0]    wrData,
  output logic [ctlPkg::SysCtlWidth-1:0]  sysCtl,
  output logic [ctlPkg::MemWaitWidth-1:0] memWait,
  output logic [ctlPkg::TimerWidth-1:0]   timer,
  output logic [ctlPkg::PatternWidth-1:0] pattern,
  output logic [ctlPkg::IntMaskWidth-1:0] intMask
);

  logic writeOk;

  // Clock hold freezes the whole bank.
  assign writeOk = wrEn & ~hold;

  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      sysCtl  <= ctlPkg::SysCtlReset;
      memWait <= ctlPkg::MemWaitReset;
      timer   <= ctlPkg::TimerReset;
      pattern <= ctlPkg::PatternReset;
      intMask <= ctlPkg::IntMaskReset;
    end else if (writeOk) begin
      // Upper data bits beyond a register's width are dropped.
      case (sel)
        ctlPkg::RegSysCtl: begin
          sysCtl <= wrData[ctlPkg::SysCtlWidth-1:0];
        end
        ctlPkg::RegMemWait: begin
          memWait <= wrData[ctlPkg::MemWaitWidth-1:0];
        end
        ctlPkg::RegTimer: begin
          timer <= wrData[ctlPkg::TimerWidth-1:0];
        end
        ctlPkg::RegPattern: begin
          pattern <= wrData[ctlPkg::PatternWidth-1:0];
        end
        ctlPkg::RegIntMask: begin
          intMask <= wrData[ctlPkg::IntMaskWidth-1:0];
        end
        default: begin
          // Flags are read only, unmapped writes vanish.
        end
      endcase
    end
  end

endmodule

// ==== hw/ctlRegTop.sv ====
module ctlRegTop #(
  parameter logic [ctlPkg::AddrWidth-1:0] BaseAddr  = 14'h3FE0,
  parameter int                           FlagCount = 4
) (
  input  logic                         CLK,
  input  logic                         CLR,
  input  logic                         access,
  input  logic                         write,
  input  logic [ctlPkg::AddrWidth-1:0] addr,
  input  logic [ctlPkg::DataWidth-1:0] wrData,
  input  logic                         hold,
  input  logic [FlagCount-1:0]         flagPins,
  output logic [ctlPkg::DataWidth-1:0] rdData,
  output logic                         rdValid
);

  ctlPkg::regSel                   sel;
  logic                            wrEn;
  logic                            rdEn;
  logic [ctlPkg::SysCtlWidth-1:0]  sysCtl;
  logic [ctlPkg::MemWaitWidth-1:0] memWait;
  logic [ctlPkg::TimerWidth-1:0]   timer;
  logic [ctlPkg::PatternWidth-1:0] pattern;
  logic [ctlPkg::IntMaskWidth-1:0] intMask;
  logic [FlagCount-1:0]            flags;

  busDecode #(.BaseAddr(BaseAddr)) decode (
    .access (access),
    .write  (write),
    .addr   (addr),
    .sel    (sel),
    .wrEn   (wrEn),
    .rdEn   (rdEn)
  );

  ctlRegBank bank (
    .CLK     (CLK),
    .CLR     (CLR),
    .hold    (hold),
    .sel     (sel),
    .wrEn    (wrEn),
    .wrData  (wrData),
    .sysCtl  (sysCtl),
    .memWait (memWait),
    .timer   (timer),
    .pattern (pattern),
    .intMask (intMask)
  );

  flagDebounce #(.FlagCount(FlagCount)) debounce (
    .CLK      (CLK),
    .CLR      (CLR),
    .flagPins (flagPins),
    .flags    (flags)
  );

  readPort #(.FlagCount(FlagCount)) readOut (
    .CLK     (CLK),
    .CLR     (CLR),
    .sel     (sel),
    .rdEn    (rdEn),
    .sysCtl  (sysCtl),
    .memWait (memWait),
    .timer   (timer),
    .pattern (pattern),
    .intMask (intMask),
    .flags   (flags),
    .rdData  (rdData),
    .rdValid (rdValid)
  );

endmodule

// ==== hw/flagDebounce.sv ====
module flagDebounce #(
  parameter int FlagCount = 4
) (
  input  logic                 CLK,
  input  logic                 CLR,
  input  logic [FlagCount-1:0] flagPins,
  output logic [FlagCount-1:0] flags
);

  logic [FlagCount-1:0] pinSample;
  logic [FlagCount-1:0] flagsNext;

  // Hysteresis per pin.
  // A high flag needs two low samples to fall, a low flag two high ones to rise.
  assign flagsNext = (flags & (flagPins | pinSample)) |
                     (~flags & (flagPins & pinSample));

  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      pinSample <= '0;
      flags     <= '0;
    end else begin
      pinSample <= flagPins;
      flags     <= flagsNext;
    end
  end

endmodule

// ==== hw/readPort.sv ====
module readPort #(
  parameter int FlagCount = 4
) (
  input  logic                            CLK,
  input  logic                            CLR,
  input  ctlPkg::regSel                   sel,
  input  logic                            rdEn,
  input  logic [ctlPkg::SysCtlWidth-1:0]  sysCtl,
  input  logic [ctlPkg::MemWaitWidth-1:0] memWait,
  input  logic [ctlPkg::TimerWidth-1:0]   timer,
  input  logic [ctlPkg::PatternWidth-1:0] pattern,
  input  logic [ctlPkg::IntMaskWidth-1:0] intMask,
  input  logic [FlagCount-1:0]            flags,
  output logic [ctlPkg::DataWidth-1:0]    rdData,
  output logic                            rdValid
);

  logic [ctlPkg::DataWidth-1:0] rdMux;

  // Zero extended source selection.
  always_comb begin
    rdMux = '0;
    case (sel)
      ctlPkg::RegSysCtl:  rdMux[ctlPkg::SysCtlWidth-1:0]  = sysCtl;
      ctlPkg::RegMemWait: rdMux[ctlPkg::MemWaitWidth-1:0] = memWait;
      ctlPkg::RegTimer:   rdMux[ctlPkg::TimerWidth-1:0]   = timer;
      ctlPkg::RegPattern: rdMux[ctlPkg::PatternWidth-1:0] = pattern;
      ctlPkg::RegIntMask: rdMux[ctlPkg::IntMaskWidth-1:0] = intMask;
      ctlPkg::RegFlags:   rdMux[FlagCount-1:0]            = flags;
      default:            rdMux = '0;
    endcase
  end

  // One result per read, data kept until the next read.
  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      rdData  <= '0;
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdEn;
      if (rdEn) begin
        rdData <= rdMux;
      end
    end
  end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ctlRegTopTb -f ctlRegTop.f -o simTb

# The log decides the result, so a nonzero exit here must not stop the script.
./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "Run ended without a result, see sim.log"
  exit 1
fi
echo "Run passed"

// ==== test/ctlRegTopTb.sv ====
module ctlRegTopTb;

  localparam logic [ctlPkg::AddrWidth-1:0] BaseAddr = 14'h3FE0;
  localparam int FlagCount = 4;
  // Cycles allowed for a read result to come back.
  localparam int ReadTimeout = 8;

  typedef struct packed {
    logic                         access;
    logic                         write;
    logic                         hold;
    ctlPkg::regSel                target;
    logic [ctlPkg::DataWidth-1:0] data;
    logic [FlagCount-1:0]         flagValue;
    logic [ctlPkg::DataWidth-1:0] expData;
  } stepRow;

  logic                         CLK;
  logic                         CLR;
  logic                         access;
  logic                         write;
  logic [ctlPkg::AddrWidth-1:0] addr;
  logic [ctlPkg::DataWidth-1:0] wrData;
  logic                         hold;
  logic [FlagCount-1:0]         flagPins;
  logic [ctlPkg::DataWidth-1:0] rdData;
  logic                         rdValid;

  stepRow                       steps[$];
  logic [ctlPkg::DataWidth-1:0] pendingReads[$];

  ctlRegTop #(.BaseAddr(BaseAddr), .FlagCount(FlagCount)) uut (
    .CLK      (CLK),
    .CLR      (CLR),
    .access   (access),
    .write    (write),
    .addr     (addr),
    .wrData   (wrData),
    .hold     (hold),
    .flagPins (flagPins),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #2 CLK = ~CLK;
    end
  end

  function automatic stepRow readStep(ctlPkg::regSel target, logic [FlagCount-1:0] pins,
                                      logic [ctlPkg::DataWidth-1:0] expData);
    stepRow s;
    s = '0;
    s.access = 1'b1;
    s.target = target;
    s.flagValue = pins;
    s.expData = expData;
    return s;
  endfunction

  function automatic stepRow writeStep(ctlPkg::regSel target,
                                       logic [ctlPkg::DataWidth-1:0] data, logic holdLevel);
    stepRow s;
    s = '0;
    s.access = 1'b1;
    s.write = 1'b1;
    s.hold = holdLevel;
    s.target = target;
    s.data = data;
    return s;
  endfunction

  function automatic stepRow idleStep(logic [FlagCount-1:0] pins);
    stepRow s;
    s = '0;
    s.flagValue = pins;
    return s;
  endfunction

  task automatic buildSteps();
    // Reset values, read back to back.
    steps.push_back(readStep(ctlPkg::RegSysCtl, 4'h0, 16'h0800));
    steps.push_back(readStep(ctlPkg::RegMemWait, 4'h0, 16'hC3FF));
    steps.push_back(readStep(ctlPkg::RegTimer, 4'h0, 16'h7FFF));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h0055));
    steps.push_back(readStep(ctlPkg::RegIntMask, 4'h0, 16'h0000));
    steps.push_back(readStep(ctlPkg::RegFlags, 4'h0, 16'h0000));
    steps.push_back(readStep(ctlPkg::RegNone, 4'h0, 16'h0000));
    // All ones, trimmed to each register width.
    steps.push_back(writeStep(ctlPkg::RegSysCtl, 16'hFFFF, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegMemWait, 16'hFFFF, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegTimer, 16'hFFFF, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegPattern, 16'hFFFF, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegIntMask, 16'hFFFF, 1'b0));
    steps.push_back(readStep(ctlPkg::RegSysCtl, 4'h0, 16'hFFFF));
    steps.push_back(readStep(ctlPkg::RegMemWait, 4'h0, 16'hFFFF));
    steps.push_back(readStep(ctlPkg::RegTimer, 4'h0, 16'h7FFF));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h00FF));
    steps.push_back(readStep(ctlPkg::RegIntMask, 4'h0, 16'h0FFF));
    steps.push_back(writeStep(ctlPkg::RegTimer, 16'h8001, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegPattern, 16'hA5C3, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegIntMask, 16'hF0F0, 1'b0));
    steps.push_back(readStep(ctlPkg::RegTimer, 4'h0, 16'h0001));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h00C3));
    steps.push_back(readStep(ctlPkg::RegIntMask, 4'h0, 16'h00F0));
    // Clock hold blocks the first write only.
    steps.push_back(writeStep(ctlPkg::RegPattern, 16'h003C, 1'b1));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h00C3));
    steps.push_back(writeStep(ctlPkg::RegPattern, 16'h003C, 1'b0));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h003C));
    // Unmapped and read-only targets.
    steps.push_back(writeStep(ctlPkg::RegNone, 16'h5A5A, 1'b0));
    steps.push_back(writeStep(ctlPkg::RegFlags, 16'hA5A5, 1'b0));
    steps.push_back(readStep(ctlPkg::RegNone, 4'h0, 16'h0000));
    steps.push_back(readStep(ctlPkg::RegFlags, 4'h0, 16'h0000));
    steps.push_back(readStep(ctlPkg::RegSysCtl, 4'h0, 16'hFFFF));
    steps.push_back(readStep(ctlPkg::RegMemWait, 4'h0, 16'hFFFF));
    steps.push_back(readStep(ctlPkg::RegTimer, 4'h0, 16'h0001));
    steps.push_back(readStep(ctlPkg::RegPattern, 4'h0, 16'h003C));
    steps.push_back(readStep(ctlPkg::RegIntMask, 4'h0, 16'h00F0));
    // Stable flag pattern, then a one-cycle glitch on every pin.
    steps.push_back(idleStep(4'h5));
    steps.push_back(idleStep(4'h5));
    steps.push_back(idleStep(4'h5));
    steps.push_back(readStep(ctlPkg::RegFlags, 4'h5, 16'h0005));
    steps.push_back(idleStep(4'hA));
    // Flags read on the two edges right after the glitch.
    steps.push_back(readStep(ctlPkg::RegFlags, 4'h5, 16'h0005));
    steps.push_back(readStep(ctlPkg::RegFlags, 4'h5, 16'h0005));
  endtask

  task automatic failRun();
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic checkData(input logic [ctlPkg::DataWidth-1:0] actual,
                           input logic [ctlPkg::DataWidth-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR at time %0t: rdData expected %h, actual %h", $time, expected, actual);
      failRun();
    end
  endtask

  task automatic checkValid(input bit actual, input bit expected);
    if (actual !== expected) begin
      $display("ERROR at time %0t: rdValid expected %b, actual %b", $time, expected, actual);
      failRun();
    end
  endtask

  // Called at the falling edge, where outputs are settled.
  task automatic collectResult();
    logic [ctlPkg::DataWidth-1:0] expData;
    if (rdValid) begin
      if (pendingReads.size() == 0) begin
        checkValid(rdValid, 1'b0);
      end else begin
        expData = pendingReads.pop_front();
        checkData(rdData, expData);
      end
    end
  endtask

  task automatic drainReads();
    int waited;
    waited = 0;
    while (pendingReads.size() != 0) begin
      @(posedge CLK);
      access <= 1'b0;
      @(negedge CLK);
      collectResult();
      waited++;
      if (pendingReads.size() != 0 && waited >= ReadTimeout) begin
        $display("Timed out at time %0t waiting for rdValid after a read.", $time);
        failRun();
      end
    end
  endtask

  initial begin
    int     i;
    stepRow s;
    bit     nextIsRead;
    CLR = 1'b1;
    access = 1'b0;
    write = 1'b0;
    addr = '0;
    wrData = '0;
    hold = 1'b0;
    flagPins = '0;
    buildSteps();
    repeat (2) @(posedge CLK);
    CLR <= 1'b0;
    for (i = 0; i < steps.size(); i++) begin
      s = steps[i];
      @(posedge CLK);
      access <= s.access;
      write <= s.write;
      hold <= s.hold;
      addr <= BaseAddr + 14'(s.target);
      wrData <= s.data;
      flagPins <= s.flagValue;
      @(negedge CLK);
      collectResult();
      if (s.access && !s.write) begin
        pendingReads.push_back(s.expData);
      end
      nextIsRead = 1'b0;
      if (i + 1 < steps.size()) begin
        nextIsRead = steps[i + 1].access && !steps[i + 1].write;
      end
      // Consecutive reads stay back to back.
      if (!nextIsRead) begin
        drainReads();
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== test/ctlRegTop_properties.sv ====
module ctlRegTop_properties (
  input logic CLK,
  input logic CLR,
  input logic access,
  input logic write,
  input logic rdValid
);

  // A read strobe gives its result on the next cycle.
  readGivesValid: assert property (
    @(posedge CLK) disable iff (CLR) (access && !write) |=> rdValid
  ) else $error("rdValid missing one cycle after a read");

  // No result without a read one cycle earlier.
  validNeedsRead: assert property (
    @(posedge CLK) disable iff (CLR) rdValid |-> $past(access && !write)
  ) else $error("rdValid without a preceding read");

  // Checked mid-cycle, after the reset has settled.
  quietInReset: assert property (
    @(negedge CLK) CLR |-> !rdValid
  ) else $error("rdValid high during reset");

endmodule

bind ctlRegTop ctlRegTop_properties props (
  .CLK     (CLK),
  .CLR     (CLR),
  .access  (access),
  .write   (write),
  .rdValid (rdValid)
);
